/* hw/sd_spi_clkgen.sv */
`timescale 1ns/1ps
`include "sd_spi_consts.svh"

module sd_spi_clkgen (
	input  logic                     spi_clk_i,
	input  logic                     spi_rst_i,
	input  logic                     run_i,       // High while a byte is on the wire
	input  sd_spi_pkg::sd_div_code_t div_code_i,
	output logic                     sck_o,
	output logic                     rise_o,      // Same cycle SCK goes high
	output logic                     fall_o       // Same cycle SCK goes low
);

	logic [3:0] half_lim;  // Half period minus one
	logic [3:0] cnt_q;
	logic       at_lim;

	// Code 0..3 gives 1,2,4,8 cycles per half period, the rest 16
	always_comb begin
		if (div_code_i >= `SD_SPI_DIV_MAX_CODE) begin
			half_lim = 4'hF;
		end else begin
			half_lim = (4'd1 << div_code_i) - 4'd1;
		end
	end

	assign at_lim = (cnt_q == half_lim);

	always_ff @(posedge spi_clk_i or posedge spi_rst_i) begin
		if (spi_rst_i) begin
			cnt_q  <= 4'd0;
			sck_o  <= 1'b0;
			rise_o <= 1'b0;
			fall_o <= 1'b0;
		end else if (!run_i) begin
			// Parked, SCK idles low (mode 0)
			cnt_q  <= 4'd0;
			sck_o  <= 1'b0;
			rise_o <= 1'b0;
			fall_o <= 1'b0;
		end else begin
			rise_o <= 1'b0;
			fall_o <= 1'b0;
			if (at_lim) begin
				cnt_q  <= 4'd0;
				sck_o  <= ~sck_o;
				rise_o <= ~sck_o;  // Low going high
				fall_o <= sck_o;   // High going low
			end else begin
				cnt_q <= cnt_q + 4'd1;
			end
		end
	end

endmodule

/* hw/sd_spi_cmd.sv */
`timescale 1ns/1ps

module sd_spi_cmd (
	input  logic                 spi_clk_i,
	input  logic                 spi_rst_i,
	input  sd_spi_pkg::sd_ctrl_t ctrl_i,
	input  sd_spi_pkg::sd_cmd_t  cmd_i,
	input  logic                 miso_i,
	output logic                 sck_o,
	output logic                 mosi_o,
	output logic                 ss_o,
	output sd_spi_pkg::sd_byte_t r1_o,
	output logic                 byte_done_o,   // Pulse per byte
	output logic                 frame_done_o   // Pulse per frame
);
	import sd_spi_pkg::*;

	sd_byte_req_t byte_req;  // Sequencer to shifter
	sd_byte_rsp_t byte_rsp;  // Shifter to sequencer
	logic         sck_run;
	logic         sck_rise;
	logic         sck_fall;

	// Byte order, chip select, gap, R1
	sd_spi_frame_seq frame_seq_i (
		.spi_clk_i    (spi_clk_i),
		.spi_rst_i    (spi_rst_i),
		.ctrl_i       (ctrl_i),
		.cmd_i        (cmd_i),
		.rsp_i        (byte_rsp),
		.req_o        (byte_req),
		.ss_o         (ss_o),
		.r1_o         (r1_o),
		.byte_done_o  (byte_done_o),
		.frame_done_o (frame_done_o)
	);

	// Bits on MOSI and MISO
	sd_spi_shifter shifter_i (
		.spi_clk_i   (spi_clk_i),
		.spi_rst_i   (spi_rst_i),
		.req_i       (byte_req),
		.msb_first_i (ctrl_i.msb_first),
		.miso_i      (miso_i),
		.rise_i      (sck_rise),
		.fall_i      (sck_fall),
		.sck_run_o   (sck_run),
		.mosi_o      (mosi_o),
		.rsp_o       (byte_rsp)
	);

	// SCK itself
	sd_spi_clkgen clkgen_i (
		.spi_clk_i  (spi_clk_i),
		.spi_rst_i  (spi_rst_i),
		.run_i      (sck_run),
		.div_code_i (ctrl_i.div_code),
		.sck_o      (sck_o),
		.rise_o     (sck_rise),
		.fall_o     (sck_fall)
	);

endmodule

/* hw/sd_spi_consts.svh */
`ifndef SD_SPI_CONSTS_SVH
`define SD_SPI_CONSTS_SVH

// Frame layout
// Command bytes go out first, MSB byte leading
`define SD_SPI_CMD_BYTES 6

// Six command bytes plus two listen bytes
`define SD_SPI_FRAME_BYTES 8

// Inter-byte gap
// spi_clk_i cycles with SCK parked low after each byte
`define SD_SPI_GAP_CYCLES 9

// Sent while the card answers, keeps MOSI high
`define SD_SPI_FILL_BYTE 8'hFF

// Divider
// Half period is 2**code cycles, codes from here up saturate at 16
`define SD_SPI_DIV_MAX_CODE 3'd4

`endif

/* hw/sd_spi_frame_seq.sv */
`timescale 1ns/1ps
`include "sd_spi_consts.svh"

module sd_spi_frame_seq (
	input  logic                     spi_clk_i,
	input  logic                     spi_rst_i,
	input  sd_spi_pkg::sd_ctrl_t     ctrl_i,
	input  sd_spi_pkg::sd_cmd_t      cmd_i,      // Stable until frame_done_o
	input  sd_spi_pkg::sd_byte_rsp_t rsp_i,
	output sd_spi_pkg::sd_byte_req_t req_o,
	output logic                     ss_o,       // Active low chip select
	output sd_spi_pkg::sd_byte_t     r1_o,
	output logic                     byte_done_o,
	output logic                     frame_done_o
);
	import sd_spi_pkg::*;

	sd_seq_state_t state_q;
	sd_byte_idx_t  idx_q;      // Slot of the byte in flight or next
	logic [3:0]    gap_q;      // Gap countdown, zero when not in a gap
	logic          load_q;
	logic          ss_q;
	sd_byte_t      tx_byte_q;  // Byte offered to the shifter
	logic          go;
	logic          last_byte;

	// Slots 0..5 carry the command top byte first, then filler
	function automatic sd_byte_t pick_byte(sd_cmd_t cmd, sd_byte_idx_t idx);
		if (idx < 3'(`SD_SPI_CMD_BYTES)) begin
			return cmd[8 * (`SD_SPI_CMD_BYTES - 1 - int'(idx)) +: 8];
		end
		return `SD_SPI_FILL_BYTE;
	endfunction

	assign go        = ctrl_i.enable && ctrl_i.start;
	assign last_byte = (idx_q == 3'(`SD_SPI_FRAME_BYTES - 1));

	assign req_o        = '{load: load_q, data: tx_byte_q};
	assign ss_o         = ss_q;
	assign frame_done_o = (state_q == SEQ_FINISH);  // Exactly one cycle

	always_ff @(posedge spi_clk_i or posedge spi_rst_i) begin
		if (spi_rst_i) begin
			state_q     <= SEQ_IDLE;
			idx_q       <= '0;
			gap_q       <= 4'd0;
			load_q      <= 1'b0;
			ss_q        <= 1'b1;  // Deselected out of reset
			r1_o        <= 8'hFF;
			byte_done_o <= 1'b0;
		end else begin
			load_q      <= 1'b0;
			byte_done_o <= 1'b0;
			case (state_q)
				SEQ_IDLE: begin
					// Start level only looked at here
					if (go) begin
						state_q <= SEQ_SEND;
						gap_q   <= 4'd0;
						load_q  <= 1'b1;            // Byte 0 right away
						ss_q    <= ctrl_i.ss_high;  // Low unless clock train
					end
				end
				SEQ_SEND: begin
					if (rsp_i.done) begin
						byte_done_o <= 1'b1;
						if (last_byte) begin
							r1_o    <= rsp_i.data;  // Last reply byte is R1
							state_q <= SEQ_FINISH;
						end else begin
							idx_q <= idx_q + 3'd1;
							gap_q <= 4'(`SD_SPI_GAP_CYCLES);
						end
					end else if (gap_q != 4'd0) begin
						gap_q <= gap_q - 4'd1;
						if (gap_q == 4'd1) begin
							load_q <= 1'b1;  // Gap over, next byte
						end
					end
				end
				SEQ_FINISH: begin
					state_q <= SEQ_IDLE;
					idx_q   <= '0;    // Ready for byte 0 of the next frame
					ss_q    <= 1'b1;
				end
				default: begin
					state_q <= SEQ_IDLE;
				end
			endcase
		end
	end

	// Index moves at done, well ahead of the load
	always_ff @(posedge spi_clk_i) begin
		tx_byte_q <= pick_byte(cmd_i, idx_q);
	end

endmodule

/* hw/sd_spi_pkg.sv */
package sd_spi_pkg;

	typedef logic [7:0]  sd_byte_t;      // One SPI byte
	typedef logic [47:0] sd_cmd_t;       // Full SD command, top byte first
	typedef logic [2:0]  sd_div_code_t;  // SCK divider code
	typedef logic [2:0]  sd_byte_idx_t;  // Byte slot inside a frame

	// Frame sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE,    // Deselected, waiting for start
		SEQ_SEND,    // Bytes and gaps
		SEQ_FINISH   // One cycle, frame end pulse
	} sd_seq_state_t;

	// Control word from the host side
	typedef struct packed {
		logic         enable;     // Block enable
		logic         start;      // Level, sampled in idle only
		logic         ss_high;    // Keep chip select high, power-up clocks
		logic         msb_first;  // Bit order on the wire
		sd_div_code_t div_code;
	} sd_ctrl_t;

	// Sequencer to shifter
	typedef struct packed {
		logic     load;  // One cycle, starts a byte
		sd_byte_t data;
	} sd_byte_req_t;

	// Shifter back to sequencer
	typedef struct packed {
		logic     done;  // One cycle after the last falling tick
		sd_byte_t data;  // Byte seen on MISO
	} sd_byte_rsp_t;

endpackage

/* hw/sd_spi_shifter.sv */
`timescale 1ns/1ps

module sd_spi_shifter (
	input  logic                     spi_clk_i,
	input  logic                     spi_rst_i,
	input  sd_spi_pkg::sd_byte_req_t req_i,
	input  logic                     msb_first_i,
	input  logic                     miso_i,
	input  logic                     rise_i,       // SCK rising tick
	input  logic                     fall_i,       // SCK falling tick
	output logic                     sck_run_o,    // Enables the divider
	output logic                     mosi_o,
	output sd_spi_pkg::sd_byte_rsp_t rsp_o
);
	import sd_spi_pkg::*;

	sd_byte_t   tx_q;       // Outgoing bits, ones fill in behind
	sd_byte_t   rx_q;       // Incoming bits
	logic [3:0] bit_cnt_q;  // Rising ticks seen, 0..8
	logic       busy_q;
	logic       done_q;
	logic       last_fall;

	// Falling tick that closes the eighth bit
	assign last_fall = busy_q && fall_i && (bit_cnt_q == 4'd8);

	// Drop run in the same cycle as the last fall
	// so the divider cannot fire another edge at fast codes
	assign sck_run_o = busy_q && !last_fall;

	// Wire bit picked by order
	assign mosi_o = msb_first_i ? tx_q[7] : tx_q[0];

	assign rsp_o = '{done: done_q, data: rx_q};

	always_ff @(posedge spi_clk_i or posedge spi_rst_i) begin
		if (spi_rst_i) begin
			tx_q      <= 8'hFF;  // MOSI idles high
			bit_cnt_q <= 4'd0;
			busy_q    <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			done_q <= last_fall;
			if (req_i.load) begin
				// First bit is on MOSI before the first rising edge
				tx_q      <= req_i.data;
				bit_cnt_q <= 4'd0;
				busy_q    <= 1'b1;
			end else if (busy_q) begin
				if (rise_i) begin
					bit_cnt_q <= bit_cnt_q + 4'd1;
				end
				if (fall_i) begin
					// Shift on every fall, eight shifts leave all ones
					if (msb_first_i) begin
						tx_q <= {tx_q[6:0], 1'b1};
					end else begin
						tx_q <= {1'b1, tx_q[7:1]};
					end
				end
				if (last_fall) begin
					busy_q <= 1'b0;
				end
			end
		end
	end

	// MISO sampled on the rising tick, same order as transmit
	always_ff @(posedge spi_clk_i) begin
		if (busy_q && rise_i) begin
			if (msb_first_i) begin
				rx_q <= {rx_q[6:0], miso_i};
			end else begin
				rx_q <= {miso_i, rx_q[7:1]};
			end
		end
	end

endmodule

/* sd_spi_cmd.f */
+incdir+hw
hw/sd_spi_pkg.sv
hw/sd_spi_clkgen.sv
hw/sd_spi_shifter.sv
hw/sd_spi_frame_seq.sv
hw/sd_spi_cmd.sv
sim/sd_spi_cmd_properties.sv
sim/sd_spi_cmd_tb.sv

/* sim/sd_spi_cmd_properties.sv */
`timescale 1ns/1ps

module sd_spi_cmd_properties (
	input logic                      spi_clk_i,
	input logic                      spi_rst_i,
	input logic                      sck_i,
	input logic                      ss_i,
	input logic                      byte_done_i,
	input logic                      frame_done_i,
	input sd_spi_pkg::sd_seq_state_t seq_state_i   // Sequencer state, from inside the DUT
);
	import sd_spi_pkg::*;

	int unsigned fail_cnt = 0;  // Failure count, watched by the testbench
	logic [3:0]  done_seen_q;   // byte_done pulses since the last frame end

	always_ff @(posedge spi_clk_i or posedge spi_rst_i) begin
		if (spi_rst_i) begin
			done_seen_q <= 4'd0;
		end else if (frame_done_i) begin
			done_seen_q <= 4'd0;  // Next frame counts from zero
		end else if (byte_done_i) begin
			done_seen_q <= done_seen_q + 4'd1;
		end
	end

	// Card deselected whenever the sequencer waits
	idle_ss_high_a: assert property (
		@(posedge spi_clk_i) disable iff (spi_rst_i)
		(seq_state_i == SEQ_IDLE) |-> ss_i
	) else begin
		fail_cnt++;
		$error("ss_o low while the sequencer is idle");
	end

	// SCK parked low by the time chip select lets go
	ss_rise_sck_low_a: assert property (
		@(posedge spi_clk_i) disable iff (spi_rst_i)
		$rose(ss_i) |-> !sck_i
	) else begin
		fail_cnt++;
		$error("sck_o high when ss_o went high");
	end

	frame_done_pulse_a: assert property (
		@(posedge spi_clk_i) disable iff (spi_rst_i)
		frame_done_i |=> !frame_done_i
	) else begin
		fail_cnt++;
		$error("frame_done_o longer than one cycle");
	end

	// Only the last byte's done lines up with the frame end
	// seven earlier dones mean this one is byte 7
	done_overlap_last_a: assert property (
		@(posedge spi_clk_i) disable iff (spi_rst_i)
		(byte_done_i && frame_done_i) |-> (done_seen_q == 4'd7)
	) else begin
		fail_cnt++;
		$error("byte_done_o with frame_done_o for a byte other than byte 7");
	end

endmodule

/* sim/sd_spi_cmd_tb.sv */
`timescale 1ns/1ps
`include "sd_spi_consts.svh"

module sd_spi_cmd_tb;
	import sd_spi_pkg::*;

	// Slowest byte is eight SCK periods of 2x16 cycles, a few more for load and done
	localparam int FRAME_COUNT    = 14;
	localparam int SLOW_BYTE      = 8 * 2 * 16 + 4;
	localparam int TIMEOUT_CYCLES =
		FRAME_COUNT * `SD_SPI_FRAME_BYTES * (SLOW_BYTE + `SD_SPI_GAP_CYCLES) + 200 + 2000;

	logic     spi_clk_i;
	logic     spi_rst_i;
	sd_ctrl_t ctrl_i;
	sd_cmd_t  cmd_i;
	logic     miso_i;
	logic     sck_o;
	logic     mosi_o;
	logic     ss_o;
	sd_byte_t r1_o;
	logic     byte_done_o;
	logic     frame_done_o;

	logic [31:0] lcg_state = 32'hbe17f32e;
	int          cycle_cnt = 0;
	sd_byte_t    reply_bytes [8];  // Card answer, one per frame slot
	int          card_bit;         // Bit position inside the frame
	logic        card_sck_prev = 1'b0;

	// Monitor state, cleared per frame
	sd_byte_t mosi_bytes [$];
	int       rise_periods [$];  // Cycles between rises inside a byte
	sd_byte_t mon_shift;
	int       mon_bits;
	int       mon_cyc = 0;
	int       last_rise_cyc;
	logic     mon_sck_prev = 1'b0;
	logic     sck_started;
	int       sck_edges;
	int       byte_done_cnt;
	int       frame_done_cnt;
	int       ss_low_cnt;
	int       ss_gap_cnt;  // ss_o high between first SCK edge and frame end

	sd_spi_cmd sd_spi_cmd_i (.*);

	bind sd_spi_cmd sd_spi_cmd_properties props_i (
		.spi_clk_i    (spi_clk_i),
		.spi_rst_i    (spi_rst_i),
		.sck_i        (sck_o),
		.ss_i         (ss_o),
		.byte_done_i  (byte_done_o),
		.frame_done_i (frame_done_o),
		.seq_state_i  (frame_seq_i.state_q)
	);

	initial begin
		spi_clk_i = 1'b0;
		forever #4 spi_clk_i = ~spi_clk_i;
	end

	always @(posedge spi_clk_i) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("Timeout: no frame end after %0d cycles, the DUT seems stuck", cycle_cnt);
			stop_on_failure();
		end
	end

	// Bound checker failures end the run at once
	always @(negedge spi_clk_i) begin
		if (sd_spi_cmd_i.props_i.fail_cnt != 0) begin
			$display("A bound assertion on the DUT failed");
			stop_on_failure();
		end
	end

	function automatic logic card_bit_value(int idx);
		sd_byte_t b;
		int       k;
		if (idx >= 8 * `SD_SPI_FRAME_BYTES) begin
			return 1'b1;
		end
		b = reply_bytes[idx / 8];
		k = idx % 8;
		return ctrl_i.msb_first ? b[7 - k] : b[k];
	endfunction

	// Card on MISO, next bit after each SCK fall
	always @(negedge spi_clk_i) begin
		if (ss_o) begin
			card_bit = 0;
			miso_i <= 1'b1;  // Released line pulls high
		end else begin
			if (card_sck_prev && !sck_o) begin
				card_bit = card_bit + 1;
			end
			miso_i <= card_bit_value(card_bit);
		end
		card_sck_prev = sck_o;
	end

	// MOSI capture on SCK rise, pulse and chip select counts
	always @(negedge spi_clk_i) begin
		mon_cyc++;
		if (sck_o != mon_sck_prev) begin
			sck_edges++;
		end
		if (sck_o && !mon_sck_prev) begin
			if (mon_bits != 0) begin
				rise_periods.push_back(mon_cyc - last_rise_cyc);
			end
			last_rise_cyc = mon_cyc;
			sck_started   = 1'b1;
			mon_shift     = ctrl_i.msb_first ? {mon_shift[6:0], mosi_o} : {mosi_o, mon_shift[7:1]};
			mon_bits++;
			if (mon_bits == 8) begin
				mosi_bytes.push_back(mon_shift);
				mon_bits = 0;
			end
		end
		if (!ss_o) begin
			ss_low_cnt++;
		end
		if (sck_started && frame_done_cnt == 0 && ss_o) begin
			ss_gap_cnt++;
		end
		if (byte_done_o) begin
			byte_done_cnt++;
		end
		if (frame_done_o) begin
			frame_done_cnt++;
		end
		mon_sck_prev = sck_o;
	end

	task automatic stop_on_failure();
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string test_name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("Error: %s expected %0h actual %0h", test_name, expected, actual);
		stop_on_failure();
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic sd_cmd_t random_cmd();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi[15:0], lo};
	endfunction

	// Command bytes top first, filler after byte 5
	function automatic sd_byte_t expected_byte(sd_cmd_t cmd, int idx);
		sd_cmd_t shifted;
		if (idx >= `SD_SPI_CMD_BYTES) begin
			return 8'hFF;
		end
		shifted = cmd >> (8 * (5 - idx));
		return shifted[7:0];
	endfunction

	task automatic clear_monitor();
		@(posedge spi_clk_i);  // Away from the negedge the monitor runs on
		mosi_bytes.delete();
		rise_periods.delete();
		mon_bits       = 0;
		sck_started    = 1'b0;
		sck_edges      = 0;
		byte_done_cnt  = 0;
		frame_done_cnt = 0;
		ss_low_cnt     = 0;
		ss_gap_cnt     = 0;
	endtask

	task automatic run_frame(input sd_cmd_t cmd, input logic msb, input sd_div_code_t div,
		input logic ss_high);
		@(negedge spi_clk_i);
		cmd_i            = cmd;
		ctrl_i.enable    = 1'b1;
		ctrl_i.start     = 1'b1;
		ctrl_i.ss_high   = ss_high;
		ctrl_i.msb_first = msb;
		ctrl_i.div_code  = div;
		do begin
			@(negedge spi_clk_i);  // Cycle counter bounds this wait
		end while (!frame_done_o);
		ctrl_i.start = 1'b0;  // Sampled in idle only, so a single frame
		@(negedge spi_clk_i);
	endtask

	task automatic check_cmd_bytes(input string test_name, input sd_cmd_t cmd);
		assert (mosi_bytes.size() == `SD_SPI_FRAME_BYTES)
			else report_mismatch(test_name, `SD_SPI_FRAME_BYTES, mosi_bytes.size());
		for (int i = 0; i < `SD_SPI_FRAME_BYTES; i++) begin
			assert (mosi_bytes[i] == expected_byte(cmd, i))
				else report_mismatch(test_name, expected_byte(cmd, i), mosi_bytes[i]);
		end
	endtask

	task automatic cmd_msb_first();
		sd_cmd_t cmd;
		cmd = random_cmd();
		clear_monitor();
		run_frame(cmd, 1'b1, 3'd1, 1'b0);
		check_cmd_bytes("cmd_msb_first", cmd);
	endtask

	task automatic cmd_lsb_first();
		sd_cmd_t cmd;
		cmd = random_cmd();
		clear_monitor();
		run_frame(cmd, 1'b0, 3'd2, 1'b0);
		check_cmd_bytes("cmd_lsb_first", cmd);
	endtask

	task automatic r1_capture();
		logic [31:0] rnd;
		for (int f = 0; f < 3; f++) begin
			for (int i = 0; i < `SD_SPI_FRAME_BYTES; i++) begin
				rnd            = lcg_next();
				reply_bytes[i] = rnd[15:8];
			end
			run_frame(random_cmd(), f != 1, 3'd0, 1'b0);  // Middle frame LSB first
			assert (r1_o == reply_bytes[7])
				else report_mismatch("r1_capture", reply_bytes[7], r1_o);
		end
	endtask

	task automatic divider_rates();
		int half;
		for (int code = 0; code <= 5; code++) begin
			half = (code < 4) ? (1 << code) : 16;
			clear_monitor();
			run_frame(random_cmd(), 1'b1, 3'(code), 1'b0);
			// Seven rise to rise gaps per byte
			assert (rise_periods.size() == 7 * `SD_SPI_FRAME_BYTES)
				else report_mismatch("divider_rates", 7 * `SD_SPI_FRAME_BYTES, rise_periods.size());
			foreach (rise_periods[i]) begin
				assert (rise_periods[i] == 2 * half)
					else report_mismatch("divider_rates", 2 * half, rise_periods[i]);
			end
		end
	endtask

	task automatic strobe_gating();
		clear_monitor();
		run_frame(random_cmd(), 1'b1, 3'd0, 1'b0);
		assert (byte_done_cnt == 8) else report_mismatch("strobe_gating", 8, byte_done_cnt);
		assert (frame_done_cnt == 1) else report_mismatch("strobe_gating", 1, frame_done_cnt);
		@(negedge spi_clk_i);
		ctrl_i.enable = 1'b0;  // Start without enable must stay quiet
		ctrl_i.start  = 1'b1;
		clear_monitor();
		repeat (200) @(negedge spi_clk_i);
		assert (sck_edges == 0) else report_mismatch("strobe_gating", 0, sck_edges);
		assert (byte_done_cnt == 0) else report_mismatch("strobe_gating", 0, byte_done_cnt);
		assert (frame_done_cnt == 0) else report_mismatch("strobe_gating", 0, frame_done_cnt);
		ctrl_i.start = 1'b0;
	endtask

	task automatic chip_select();
		// Power-up clock train, card never selected
		clear_monitor();
		run_frame(random_cmd(), 1'b1, 3'd1, 1'b1);
		assert (ss_low_cnt == 0) else report_mismatch("chip_select", 0, ss_low_cnt);
		assert (sck_edges == 128) else report_mismatch("chip_select", 128, sck_edges);
		assert (mosi_bytes.size() == 8) else report_mismatch("chip_select", 8, mosi_bytes.size());
		clear_monitor();
		run_frame(random_cmd(), 1'b1, 3'd1, 1'b0);
		assert (ss_low_cnt > 0) else report_mismatch("chip_select", 1, ss_low_cnt);
		assert (ss_gap_cnt == 0) else report_mismatch("chip_select", 0, ss_gap_cnt);
		assert (ss_o == 1'b1) else report_mismatch("chip_select", 1, ss_o);
	endtask

	initial begin
		spi_rst_i = 1'b1;
		ctrl_i    = '0;
		cmd_i     = '0;
		miso_i    = 1'b1;
		foreach (reply_bytes[i]) begin
			reply_bytes[i] = 8'hFF;
		end
		repeat (4) @(negedge spi_clk_i);
		spi_rst_i = 1'b0;
		@(negedge spi_clk_i);
		// Idle levels out of reset
		assert ({ss_o, sck_o, mosi_o, r1_o, byte_done_o, frame_done_o} == {3'b101, 8'hFF, 2'b00})
			else report_mismatch("reset_state", {3'b101, 8'hFF, 2'b00},
				{ss_o, sck_o, mosi_o, r1_o, byte_done_o, frame_done_o});
		cmd_msb_first();
		cmd_lsb_first();
		r1_capture();
		divider_rates();
		strobe_gating();
		chip_select();
		repeat (4) @(negedge spi_clk_i);
		if (sd_spi_cmd_i.props_i.fail_cnt != 0) begin
			$display("Bound assertions failed %0d times", sd_spi_cmd_i.props_i.fail_cnt);
			stop_on_failure();
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule
